// ==== verilog/sgd_pkg.sv ====
// sizes, fixed-point widths, datapath types and sequencer state enum for the gradient engine
`default_nettype none

package sgd_pkg;

    // array geometry
    localparam int num_banks = 4;
    localparam int num_cols  = 4;

    // loss and fixed-point widths
    localparam int loss_w = 32;
    // fraction bits appended before the bit-weight shift
    localparam int frac_w = 4;
    localparam int acc_w  = loss_w + frac_w;

    // precision range, 1 to max_bits planes per chunk
    localparam int max_bits   = 16;
    localparam int bit_idx_w  = $clog2(max_bits);
    localparam int num_bits_w = $clog2(max_bits) + 1;

    // chunk counter and dimension input
    localparam int chunk_w = 12;
    localparam int dim_w   = 32;

    // loss fifo
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    // one scaled loss per bank
    typedef logic signed [loss_w-1:0] loss_t;

    // losses of all banks for one sample
    typedef loss_t [num_banks-1:0] loss_vec_t;

    // bit-plane word, column c of bank b sits at c + b * num_cols
    typedef logic [num_banks*num_cols-1:0] a_word_t;

    // masked column sums out of the adder tree
    typedef loss_t [num_cols-1:0] sum_vec_t;

    // fixed-point accumulator
    typedef logic signed [acc_w-1:0] acc_t;

    // one gradient per column
    typedef loss_t [num_cols-1:0] grad_vec_t;

    // plane sequencer states
    typedef enum logic [1:0] {
        seq_idle,
        seq_load,
        seq_stream
    } seq_state_e;

endpackage

`default_nettype wire

// ==== verilog/plane_if.sv ====
// plane_if interface: one bit-plane step with losses, bit position and last flag
`default_nettype none

interface plane_if #(
    parameter type word_t = logic,
    parameter type vec_t  = logic,
    parameter int  idx_w  = 1
) ();

    // one item per cycle while high, no back-pressure
    logic             valid;
    // bit-plane word as returned by the store
    word_t            a_word;
    // staged losses of the current sample
    vec_t             losses;
    // plane position inside the chunk, 0 first
    logic [idx_w-1:0] bit_index;
    // set on the final plane of a chunk
    logic             last_bit;

    modport source (
        output valid, a_word, losses, bit_index, last_bit
    );

    modport sink (
        input valid, a_word, losses, bit_index, last_bit
    );

endinterface

`default_nettype wire

// ==== verilog/loss_fifo.sv ====
// loss_fifo: circular buffer of loss vectors with registered read data
`default_nettype none

module loss_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  sgd_pkg::loss_vec_t wr_data,
    input  logic               pop,
    output sgd_pkg::loss_vec_t rd_data,
    output logic               rd_valid,
    output logic               empty,
    output logic               full
);

    // storage, one loss vector per sample
    sgd_pkg::loss_vec_t mem [sgd_pkg::fifo_depth];

    logic [sgd_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [sgd_pkg::fifo_ptr_w-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [sgd_pkg::fifo_ptr_w:0]   count;

    logic push_ok;
    logic pop_ok;

    // requests against the wrong state are dropped
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (sgd_pkg::fifo_ptr_w + 1)'(sgd_pkg::fifo_depth));

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave count as is
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read data lands one cycle after pop
    always_ff @(posedge clk) begin
        if (pop_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= pop_ok;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/plane_sequencer.sv ====
// plane_sequencer: sample FSM, chunk and bit counters, store requests and plane stream
`default_nettype none

module plane_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [sgd_pkg::dim_w-1:0]       dimension,
    input  logic [sgd_pkg::num_bits_w-1:0]  num_bits,
    input  logic                            empty,
    output logic                            pop,
    input  sgd_pkg::loss_vec_t              rd_data,
    input  logic                            rd_valid,
    output logic                            a_rd_en,
    input  sgd_pkg::a_word_t                a_data,
    plane_if.source                         plane
);

    sgd_pkg::seq_state_e state;

    // losses held for the whole sample
    sgd_pkg::loss_vec_t staged;

    logic [sgd_pkg::dim_w-1:0]      chunks_full;
    logic [sgd_pkg::chunk_w-1:0]    chunk_total;
    logic [sgd_pkg::chunk_w-1:0]    chunk_left;
    logic [sgd_pkg::bit_idx_w-1:0]  bit_cnt;
    logic [sgd_pkg::num_bits_w-1:0] last_idx;
    logic                           bit_wrap;

    // chunks per sample, dimension over columns rounded up
    assign chunks_full = (dimension + (sgd_pkg::num_cols - 1)) / sgd_pkg::num_cols;
    assign chunk_total = chunks_full[sgd_pkg::chunk_w-1:0];

    // last plane of the chunk
    assign last_idx = num_bits - 1'b1;
    assign bit_wrap = ({1'b0, bit_cnt} == last_idx);

    // pop straight out of idle, no overlap with a running sample
    assign pop = (state == sgd_pkg::seq_idle) && !empty;

    // one request per streaming cycle
    assign a_rd_en = (state == sgd_pkg::seq_stream);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= sgd_pkg::seq_idle;
            bit_cnt    <= '0;
            chunk_left <= '0;
        end else begin
            case (state)
                sgd_pkg::seq_idle: begin
                    if (!empty) begin
                        state <= sgd_pkg::seq_load;
                    end
                end
                sgd_pkg::seq_load: begin
                    // losses arrive one cycle after pop
                    if (rd_valid) begin
                        bit_cnt    <= '0;
                        chunk_left <= chunk_total;
                        // zero dimension, nothing to stream
                        if (chunk_total == '0) begin
                            state <= sgd_pkg::seq_idle;
                        end else begin
                            state <= sgd_pkg::seq_stream;
                        end
                    end
                end
                sgd_pkg::seq_stream: begin
                    if (bit_wrap) begin
                        bit_cnt    <= '0;
                        chunk_left <= chunk_left - 1'b1;
                        // final request of the final chunk
                        if (chunk_left == 1) begin
                            state <= sgd_pkg::seq_idle;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= sgd_pkg::seq_idle;
                end
            endcase
        end
    end

    // capture losses for the new sample
    always_ff @(posedge clk) begin
        if ((state == sgd_pkg::seq_load) && rd_valid) begin
            staged <= rd_data;
        end
    end

    // plane step trails its request by one cycle, in line with a_data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plane.valid <= 1'b0;
        end else begin
            plane.valid <= a_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        plane.bit_index <= bit_cnt;
        plane.last_bit  <= bit_wrap;
    end

    // word comes back from the store this cycle
    assign plane.a_word = a_data;
    // staged stays put until the next pop lands
    assign plane.losses = staged;

endmodule

`default_nettype wire

// ==== verilog/masked_add_tree.sv ====
// masked_add_tree: per-column masked two-level adder tree with pipelined side-band
`default_nettype none

module masked_add_tree (
    input  logic                           clk,
    input  logic                           rst_n,
    plane_if.sink                          plane,
    output sgd_pkg::sum_vec_t              sums,
    output logic                           sums_valid,
    output logic [sgd_pkg::bit_idx_w-1:0]  sums_bit_index,
    output logic                           sums_last
);

    // stage one, pairwise masked sums per column
    sgd_pkg::loss_t pair_sum [sgd_pkg::num_cols][sgd_pkg::num_banks/2];
    logic                          pair_valid;
    logic [sgd_pkg::bit_idx_w-1:0] pair_bit_index;
    logic                          pair_last;

    // stage two input, pairs folded together
    sgd_pkg::sum_vec_t tree_sum;

    // bank b only counts when its bit for column c is set
    always_ff @(posedge clk) begin
        for (int c = 0; c < sgd_pkg::num_cols; c++) begin
            for (int p = 0; p < sgd_pkg::num_banks / 2; p++) begin
                pair_sum[c][p] <=
                    (plane.a_word[c + (2 * p) * sgd_pkg::num_cols] ?
                        plane.losses[2 * p] : '0) +
                    (plane.a_word[c + (2 * p + 1) * sgd_pkg::num_cols] ?
                        plane.losses[2 * p + 1] : '0);
            end
        end
    end

    // fold the pair sums of each column
    always_comb begin
        for (int c = 0; c < sgd_pkg::num_cols; c++) begin
            tree_sum[c] = '0;
            for (int p = 0; p < sgd_pkg::num_banks / 2; p++) begin
                tree_sum[c] = tree_sum[c] + pair_sum[c][p];
            end
        end
    end

    always_ff @(posedge clk) begin
        sums <= tree_sum;
    end

    // side-band walks the same two registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_valid <= 1'b0;
            sums_valid <= 1'b0;
        end else begin
            pair_valid <= plane.valid;
            sums_valid <= pair_valid;
        end
    end

    always_ff @(posedge clk) begin
        pair_bit_index <= plane.bit_index;
        pair_last      <= plane.last_bit;
        sums_bit_index <= pair_bit_index;
        sums_last      <= pair_last;
    end

endmodule

`default_nettype wire

// ==== verilog/bit_serial_accumulator.sv ====
// bit_serial_accumulator: bit-weight shift, fixed-point accumulation and gradient register
`default_nettype none

module bit_serial_accumulator (
    input  logic                           clk,
    input  logic                           rst_n,
    input  sgd_pkg::sum_vec_t              sums,
    input  logic                           sums_valid,
    input  logic [sgd_pkg::bit_idx_w-1:0]  sums_bit_index,
    input  logic                           sums_last,
    output sgd_pkg::grad_vec_t             grad,
    output logic                           grad_valid
);

    // bit k weighs 2^-(k+1)
    logic [sgd_pkg::num_bits_w-1:0] shift_amt;

    // shift stage
    sgd_pkg::acc_t shifted [sgd_pkg::num_cols];
    logic          shift_valid;
    logic          shift_first;
    logic          shift_last;

    // accumulate stage
    sgd_pkg::acc_t acc [sgd_pkg::num_cols];
    logic          acc_done;

    assign shift_amt = {1'b0, sums_bit_index} + 1'b1;

    // widen with zero fraction bits, then arithmetic shift
    always_ff @(posedge clk) begin
        for (int c = 0; c < sgd_pkg::num_cols; c++) begin
            shifted[c] <= $signed({sums[c], {sgd_pkg::frac_w{1'b0}}}) >>> shift_amt;
        end
        shift_first <= (sums_bit_index == '0);
        shift_last  <= sums_last;
    end

    // plane 0 restarts the sum, later planes add on
    always_ff @(posedge clk) begin
        if (shift_valid) begin
            for (int c = 0; c < sgd_pkg::num_cols; c++) begin
                if (shift_first) begin
                    acc[c] <= shifted[c];
                end else begin
                    acc[c] <= acc[c] + shifted[c];
                end
            end
        end
    end

    // drop the fraction bits on output
    always_ff @(posedge clk) begin
        if (acc_done) begin
            for (int c = 0; c < sgd_pkg::num_cols; c++) begin
                grad[c] <= acc[c][sgd_pkg::acc_w-1:sgd_pkg::frac_w];
            end
        end
    end

    // valid chain, single pulse per chunk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_valid <= 1'b0;
            acc_done    <= 1'b0;
            grad_valid  <= 1'b0;
        end else begin
            shift_valid <= sums_valid;
            acc_done    <= shift_valid && shift_last;
            grad_valid  <= acc_done;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sgd_gradient_top.sv ====
// sgd_gradient_top: loss fifo, plane sequencer, masked adder tree and accumulator chain
`default_nettype none

module sgd_gradient_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [sgd_pkg::dim_w-1:0]       dimension,
    input  logic [sgd_pkg::num_bits_w-1:0]  num_bits,
    input  sgd_pkg::loss_vec_t              loss_in,
    input  logic                            loss_push,
    output logic                            loss_full,
    output logic                            a_rd_en,
    input  sgd_pkg::a_word_t                a_data,
    output sgd_pkg::grad_vec_t              grad,
    output logic                            grad_valid
);

    // fifo to sequencer
    logic               fifo_pop;
    logic               fifo_empty;
    sgd_pkg::loss_vec_t fifo_rd_data;
    logic               fifo_rd_valid;

    // tree to accumulator
    sgd_pkg::sum_vec_t             sums;
    logic                          sums_valid;
    logic [sgd_pkg::bit_idx_w-1:0] sums_bit_index;
    logic                          sums_last;

    // sequencer to tree
    plane_if #(
        .word_t (sgd_pkg::a_word_t),
        .vec_t  (sgd_pkg::loss_vec_t),
        .idx_w  (sgd_pkg::bit_idx_w)
    ) plane_bus ();

    loss_fifo loss_fifo_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (loss_push),
        .wr_data  (loss_in),
        .pop      (fifo_pop),
        .rd_data  (fifo_rd_data),
        .rd_valid (fifo_rd_valid),
        .empty    (fifo_empty),
        .full     (loss_full)
    );

    plane_sequencer plane_sequencer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .dimension (dimension),
        .num_bits  (num_bits),
        .empty     (fifo_empty),
        .pop       (fifo_pop),
        .rd_data   (fifo_rd_data),
        .rd_valid  (fifo_rd_valid),
        .a_rd_en   (a_rd_en),
        .a_data    (a_data),
        .plane     (plane_bus.source)
    );

    masked_add_tree masked_add_tree_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .plane          (plane_bus.sink),
        .sums           (sums),
        .sums_valid     (sums_valid),
        .sums_bit_index (sums_bit_index),
        .sums_last      (sums_last)
    );

    bit_serial_accumulator bit_serial_accumulator_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .sums           (sums),
        .sums_valid     (sums_valid),
        .sums_bit_index (sums_bit_index),
        .sums_last      (sums_last),
        .grad           (grad),
        .grad_valid     (grad_valid)
    );

endmodule

`default_nettype wire

// ==== bench/gradient_model.svh ====
// gradient reference model: pending sample queues, per-column accumulators, expected results
`ifndef GRADIENT_MODEL_SVH
`define GRADIENT_MODEL_SVH

// samples the fifo accepted, with the shape they were pushed under
sgd_pkg::loss_vec_t pend_losses [$];
int                 pend_bits [$];
int                 pend_chunks [$];

// expected gradients in output order
sgd_pkg::grad_vec_t exp_grads [$];

// sample the store is feeding right now
sgd_pkg::loss_vec_t cur_losses;
int                 cur_bits = 1;
int                 words_left = 0;
int                 plane_k = 0;
sgd_pkg::acc_t      model_acc [sgd_pkg::num_cols];

// loss vector taken by the fifo
task automatic record_sample(input sgd_pkg::loss_vec_t losses, input int bits, input int dim);
    pend_losses.push_back(losses);
    pend_bits.push_back(bits);
    // chunks round up to whole column groups
    pend_chunks.push_back((dim + sgd_pkg::num_cols - 1) / sgd_pkg::num_cols);
endtask

// banks with a set bit for this column, 32-bit wrap like the datapath
function automatic sgd_pkg::loss_t masked_sum(input sgd_pkg::a_word_t word,
                                              input sgd_pkg::loss_vec_t losses, input int col);
    sgd_pkg::loss_t sum;
    sum = '0;
    for (int b = 0; b < sgd_pkg::num_banks; b++) begin
        if (word[col + b * sgd_pkg::num_cols]) begin
            sum = sum + losses[b];
        end
    end
    return sum;
endfunction

// plane k weighs 2^-(k+1), four fraction bits kept
function automatic sgd_pkg::acc_t plane_weight(input sgd_pkg::loss_t sum, input int k);
    sgd_pkg::acc_t wide;
    wide = {sum, {sgd_pkg::frac_w{1'b0}}};
    return wide >>> (k + 1);
endfunction

// one word from the store, in request order
task automatic model_word(input sgd_pkg::a_word_t word);
    sgd_pkg::grad_vec_t g;
    if (words_left == 0) begin
        assert (pend_losses.size() != 0) else begin
            $display("store request at %0t with no sample waiting in the fifo", $time);
            mon_errors++;
        end
        if (pend_losses.size() != 0) begin
            cur_losses = pend_losses.pop_front();
            cur_bits   = pend_bits.pop_front();
            words_left = cur_bits * pend_chunks.pop_front();
            plane_k    = 0;
        end
    end
    for (int c = 0; c < sgd_pkg::num_cols; c++) begin
        // plane 0 restarts the column
        if (plane_k == 0) begin
            model_acc[c] = plane_weight(masked_sum(word, cur_losses, c), plane_k);
        end else begin
            model_acc[c] = model_acc[c] + plane_weight(masked_sum(word, cur_losses, c), plane_k);
        end
        g[c] = model_acc[c][sgd_pkg::acc_w-1:sgd_pkg::frac_w];
    end
    words_left--;
    if (plane_k == cur_bits - 1) begin
        exp_grads.push_back(g);
        plane_k = 0;
    end else begin
        plane_k++;
    end
endtask

`endif

// ==== bench/tb_sgd_gradient.sv ====
// testbench for sgd_gradient_top: clock, reset, seeded samples, store model, checks, watchdog
`default_nettype none

module tb_sgd_gradient;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_rand  = 40;
    localparam int burst_len = 8;

    logic                           clk;
    logic                           rst_n;
    logic [sgd_pkg::dim_w-1:0]      dimension;
    logic [sgd_pkg::num_bits_w-1:0] num_bits;
    sgd_pkg::loss_vec_t             loss_in;
    logic                           loss_push;
    logic                           loss_full;
    logic                           a_rd_en;
    sgd_pkg::a_word_t               a_data;
    sgd_pkg::grad_vec_t             grad;
    logic                           grad_valid;

    int seed = 59;
    // store words come from a second copy of the seed
    int store_seed = 59;

    // written by the bus process only
    int mon_errors  = 0;
    int grads_seen  = 0;
    int rd_count    = 0;
    int full_cycles = 0;

    // written by the main sequence only
    int seq_errors   = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int exp_total    = 0;

    // random sample shapes, drawn before the run
    int   rand_bits [num_rand];
    int   rand_dim [num_rand];
    int   limit_ns = 0;
    logic limit_ready = 1'b0;

    `include "gradient_model.svh"

    sgd_gradient_top sgd_gradient_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .dimension  (dimension),
        .num_bits   (num_bits),
        .loss_in    (loss_in),
        .loss_push  (loss_push),
        .loss_full  (loss_full),
        .a_rd_en    (a_rd_en),
        .a_data     (a_data),
        .grad       (grad),
        .grad_valid (grad_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int total_errors();
        return mon_errors + seq_errors;
    endfunction

    // compare one gradient vector against the oldest expected one
    task automatic check_grad();
        sgd_pkg::grad_vec_t want;
        grads_seen++;
        assert (exp_grads.size() != 0) else begin
            $display("grad_valid pulsed at %0t with no result expected", $time);
            mon_errors++;
        end
        if (exp_grads.size() != 0) begin
            want = exp_grads.pop_front();
            for (int c = 0; c < sgd_pkg::num_cols; c++) begin
                assert (grad[c] === want[c]) else begin
                    $display("Error at %0t: column %0d gradient %h, expected %h",
                             $time, c, grad[c], want[c]);
                    mon_errors++;
                end
            end
        end
    endtask

    // outputs sampled at the falling edge, store answers after the rising edge
    initial begin
        int   r;
        logic want_word;
        a_data = '0;
        forever begin
            @(negedge clk);
            want_word = (a_rd_en === 1'b1);
            if (want_word) begin
                rd_count++;
            end
            if (loss_full === 1'b1) begin
                full_cycles++;
            end
            // push on a full fifo is dropped by the DUT
            if (loss_push === 1'b1 && loss_full !== 1'b1) begin
                record_sample(loss_in, int'(num_bits), int'(dimension));
            end
            if (grad_valid === 1'b1) begin
                check_grad();
            end
            @(posedge clk);
            #1;
            if (want_word) begin
                r      = $random(store_seed);
                a_data = r[sgd_pkg::num_banks*sgd_pkg::num_cols-1:0];
                model_word(a_data);
            end
        end
    end

    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("watchdog expired at %0t, the run did not finish in time", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // mostly plain random, with the extremes mixed in
    function automatic sgd_pkg::loss_t random_loss();
        int r;
        r = $random(seed);
        case (r[2:0])
            3'd0: return 32'sh7fffffff;
            3'd1: return 32'sh80000000;
            3'd2: return 32'shffffffff;
            default: return $random(seed);
        endcase
    endfunction

    task automatic push_losses(input sgd_pkg::loss_vec_t losses);
        loss_in   = losses;
        loss_push = 1'b1;
        next_cycle();
        loss_push = 1'b0;
    endtask

    task automatic wait_grads(input int target);
        while (grads_seen < target) begin
            next_cycle();
        end
    endtask

    // one sample alone in the engine, then its request count
    task automatic run_sample(input int bits, input int dim, input sgd_pkg::loss_vec_t losses);
        int rd_start;
        int chunks;
        chunks    = (dim + sgd_pkg::num_cols - 1) / sgd_pkg::num_cols;
        num_bits  = bits[sgd_pkg::num_bits_w-1:0];
        dimension = dim;
        rd_start  = rd_count;
        push_losses(losses);
        exp_total += chunks;
        wait_grads(exp_total);
        assert (rd_count - rd_start == chunks * bits) else begin
            $display("Error at %0t: %0d store requests for %0d chunks of %0d bits",
                     $time, rd_count - rd_start, chunks, bits);
            seq_errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (total_errors() == err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, total_errors() - err_start);
        end
    endtask

    initial begin
        int                 err_start;
        int                 planes;
        int                 rd_start;
        int                 full_start;
        int                 r;
        sgd_pkg::loss_vec_t losses;

        rst_n     = 1'b0;
        dimension = 4;
        num_bits  = 5'd1;
        loss_in   = '0;
        loss_push = 1'b0;

        // single-plane sample plus the burst, 16 bits over 8 chunks each
        planes = 1 + (burst_len + 1) * 16 * 8;
        for (int i = 0; i < num_rand; i++) begin
            r            = $random(seed);
            rand_bits[i] = int'(r[3:0]) + 1;
            rand_dim[i]  = int'(r[8:4]) + 1;
            planes       = planes + rand_bits[i] * ((rand_dim[i] + 3) / 4);
        end
        // push, pop, load and pipeline drain cost each sample a few cycles
        limit_ns    = (planes + 16 * (num_rand + burst_len + 4)) * 10 + 2000;
        limit_ready = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        err_start = total_errors();
        repeat (8) begin
            @(negedge clk);
            assert (a_rd_en === 1'b0 && grad_valid === 1'b0 && loss_full === 1'b0) else begin
                $display("Error at %0t: a_rd_en %b grad_valid %b loss_full %b after reset",
                         $time, a_rd_en, grad_valid, loss_full);
                seq_errors++;
            end
        end
        next_cycle();
        report_test("reset idle", err_start);

        err_start = total_errors();
        losses[0] = 32'sd1000;
        losses[1] = -32'sd37;
        losses[2] = 32'sd5;
        losses[3] = 32'sh7fffffff;
        run_sample(1, 4, losses);
        report_test("single plane", err_start);

        err_start = total_errors();
        for (int i = 0; i < num_rand; i++) begin
            for (int b = 0; b < sgd_pkg::num_banks; b++) begin
                losses[b] = random_loss();
            end
            run_sample(rand_bits[i], rand_dim[i], losses);
        end
        report_test("random samples and request counts", err_start);

        err_start  = total_errors();
        num_bits   = 5'd16;
        dimension  = 32;
        rd_start   = rd_count;
        full_start = full_cycles;
        // sequencer busy on this one while the burst lands
        for (int b = 0; b < sgd_pkg::num_banks; b++) begin
            losses[b] = random_loss();
        end
        push_losses(losses);
        while (a_rd_en !== 1'b1) begin
            next_cycle();
        end
        for (int i = 0; i < burst_len; i++) begin
            for (int b = 0; b < sgd_pkg::num_banks; b++) begin
                losses[b] = random_loss();
            end
            assert (loss_full !== 1'b1) else begin
                $display("loss_full was already high before push %0d of the burst", i);
                seq_errors++;
            end
            loss_in   = losses;
            loss_push = 1'b1;
            next_cycle();
        end
        loss_push = 1'b0;
        exp_total += (burst_len + 1) * 8;
        wait_grads(exp_total);
        assert (full_cycles > full_start) else begin
            $display("loss_full never rose during the burst");
            seq_errors++;
        end
        assert (rd_count - rd_start == (burst_len + 1) * 8 * 16) else begin
            $display("Error at %0t: %0d store requests in the burst, expected %0d",
                     $time, rd_count - rd_start, (burst_len + 1) * 8 * 16);
            seq_errors++;
        end
        report_test("fifo burst", err_start);

        // no stray pulses after the last result
        repeat (20) next_cycle();
        assert (grads_seen == exp_total && exp_grads.size() == 0) else begin
            $display("Error at %0t: %0d gradients seen, %0d expected, %0d still queued",
                     $time, grads_seen, exp_total, exp_grads.size());
            seq_errors++;
        end

        $display("tests passed %0d failed %0d, gradients %0d, errors %0d",
                 tests_passed, tests_failed, grads_seen, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+bench
verilog/sgd_pkg.sv
verilog/plane_if.sv
verilog/loss_fifo.sv
verilog/plane_sequencer.sv
verilog/masked_add_tree.sv
verilog/bit_serial_accumulator.sv
verilog/sgd_gradient_top.sv
bench/tb_sgd_gradient.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the gradient engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_sgd_gradient -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
